// ==== rtl/posit_config.svh ====
// Posit format and result queue sizing for the posit adder RTL
// Include in any file that needs the widths or the queue depth
`ifndef POSIT_CONFIG_SVH
`define POSIT_CONFIG_SVH

// Posit word and exponent size
`define POSIT_N 16
`define POSIT_ES 1

// Two's complement scale width for values up to plus or minus 28
`define POSIT_SCALE_W 6

// Stored raw fraction bits without the hidden bit
`define POSIT_FRAC_W (`POSIT_N - 3 - `POSIT_ES)

// Adder working width holds hidden bit, fraction, guard, round and a spare bit
`define POSIT_ABITS (`POSIT_FRAC_W + 4)

// Result queue entries and the input credits upstream starts with
`define POSIT_QUEUE_DEPTH 8

`endif

// ==== rtl/posit_pkg.sv ====
// Opcode and raw value types shared by the posit adder stages
// Modules import it in their body and use scoped names in port lists
`default_nettype none

`include "posit_config.svh"

package posit_pkg;

    typedef enum logic
    {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } posit_op_e;

    typedef logic [`POSIT_N-1:0] posit_t;

    // Unpacked operand, scale is two's complement
    typedef struct packed
    {
        logic                       sgn;
        logic [`POSIT_SCALE_W-1:0]  scale;
        logic [`POSIT_FRAC_W-1:0]   fraction;
        logic                       nar;
        logic                       zero;
        logic                       truncated;
    } raw_value_t;

    // Adder result with one extra scale bit for carry out
    // Fraction keeps guard and round below the stored bits
    typedef struct packed
    {
        logic                       sgn;
        logic [`POSIT_SCALE_W:0]    scale;
        logic [`POSIT_FRAC_W+1:0]   fraction;
        logic                       nar;
        logic                       zero;
        logic                       sticky;
    } raw_sum_t;

endpackage

`default_nettype wire

// ==== rtl/posit_raw_if.sv ====
// Valid plus raw payload between the adder stages
// Operand links use a and b, the sum link uses s
`timescale 1ns/1ps
`default_nettype none

interface posit_raw_if;
    import posit_pkg::*;

    logic       valid;
    raw_value_t a;
    raw_value_t b;
    raw_sum_t   s;

    // Producer side
    modport src (
        output valid,
        output a,
        output b,
        output s
    );

    // Consumer side
    modport dst (
        input valid,
        input a,
        input b,
        input s
    );

endinterface

`default_nettype wire

// ==== rtl/posit_decode.sv ====
// Unpacks two posit operands into raw values for the adder pipeline
// One register stage, subtract is folded into the sign of b
`timescale 1ns/1ps
`default_nettype none

`include "posit_config.svh"

module posit_decode (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  posit_pkg::posit_op_e in_op,
    input  posit_pkg::posit_t    in_a,
    input  posit_pkg::posit_t    in_b,
    posit_raw_if.src             raw
);
    import posit_pkg::*;

    localparam int N  = `POSIT_N;
    localparam int ES = `POSIT_ES;
    localparam int SW = `POSIT_SCALE_W;
    localparam int FW = `POSIT_FRAC_W;

    function automatic raw_value_t decode_posit(input posit_t p);
        raw_value_t   v;
        posit_t       mag;
        logic [N-2:0] body;
        logic [N-2:0] rest;
        int           run;
        int           k;
        logic         ended;

        v = '0;
        mag = p[N-1] ? -p : p;
        body = mag[N-2:0];

        // Length of the regime run
        run = 0;
        ended = 1'b0;
        for (int i = N - 2; i >= 0; i--)
        begin
            if (!ended && body[i] == body[N-2])
                run++;
            else
                ended = 1'b1;
        end
        k = body[N-2] ? run - 1 : -run;

        // Drop regime and terminator, exponent then fraction remain
        rest = body << (run + 1);
        v.sgn = p[N-1];
        v.scale = SW'(k * (1 << ES) + int'(rest[N-2 -: ES]));
        v.fraction = rest[N-2-ES -: FW];
        v.zero = (p == '0);
        v.nar = (p == {1'b1, {(N-1){1'b0}}});

        if (v.zero || v.nar)
        begin
            v.sgn = 1'b0;
            v.scale = '0;
            v.fraction = '0;
        end
        // Posit inputs are exact
        v.truncated = 1'b0;
        return v;
    endfunction

    raw_value_t a_dec;
    raw_value_t b_dec;

    assign a_dec = decode_posit(in_a);

    always_comb
    begin
        b_dec = decode_posit(in_b);
        if (in_op == OP_SUB && !b_dec.zero && !b_dec.nar)
        begin
            b_dec.sgn = ~b_dec.sgn;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            raw.valid <= 1'b0;
        else
            raw.valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        raw.a <= a_dec;
        raw.b <= b_dec;
    end

    // No sum on the operand link
    assign raw.s = '0;

endmodule

`default_nettype wire

// ==== rtl/posit_add_raw.sv ====
// Four-stage raw posit adder: order, align and add, normalize, output
// Takes an operand pair every cycle without stalls
`timescale 1ns/1ps
`default_nettype none

`include "posit_config.svh"

module posit_add_raw (
    input  logic     clk,
    input  logic     reset,
    posit_raw_if.dst src,
    posit_raw_if.src sum
);
    import posit_pkg::*;

    localparam int ABITS = `POSIT_ABITS;
    localparam int FW    = `POSIT_FRAC_W;
    localparam int SW    = `POSIT_SCALE_W;
    localparam int DW    = SW + 1;
    localparam int LW    = $clog2(ABITS + 1);
    localparam int PAD   = ABITS - FW - 1;

    // Stage 0 orders by magnitude, hi is the larger operand
    raw_value_t      s0_hi;
    raw_value_t      s0_lo;
    logic            s0_a_ge_b;
    logic [DW-1:0]   s0_diff;

    assign s0_a_ge_b = src.b.zero
        | (~src.a.zero & (($signed(src.a.scale) > $signed(src.b.scale))
        | ((src.a.scale == src.b.scale) & (src.a.fraction >= src.b.fraction))));
    assign s0_hi = s0_a_ge_b ? src.a : src.b;
    assign s0_lo = s0_a_ge_b ? src.b : src.a;
    assign s0_diff = {s0_hi.scale[SW-1], s0_hi.scale} - {s0_lo.scale[SW-1], s0_lo.scale};

    logic            s1_valid;
    raw_value_t      s1_hi;
    raw_value_t      s1_lo;
    logic            s1_add;
    logic [DW-1:0]   s1_diff;
    logic            s1_trunc;

    always_ff @(posedge clk)
    begin
        s1_hi <= s0_hi;
        s1_lo <= s0_lo;
        s1_add <= (s0_hi.sgn == s0_lo.sgn);
        s1_diff <= s0_diff;
        s1_trunc <= src.a.truncated | src.b.truncated;
    end

    // Stage 1 aligns lo, anything shifted out goes to sticky
    logic [DW-1:0]       s1_shamt;
    logic [2*ABITS-1:0]  s1_lo_shifted;
    logic [ABITS-1:0]    s1_hi_sig;
    logic [ABITS-1:0]    s1_lo_sig;
    logic                s1_sticky;
    logic [ABITS:0]      s1_sum_raw;

    assign s1_shamt = (s1_diff > DW'(ABITS)) ? DW'(ABITS) : s1_diff;
    assign s1_lo_shifted = {~s1_lo.zero, s1_lo.fraction, {PAD{1'b0}}, {ABITS{1'b0}}} >> s1_shamt;
    assign s1_lo_sig = s1_lo_shifted[2*ABITS-1:ABITS];
    assign s1_hi_sig = {~s1_hi.zero, s1_hi.fraction, {PAD{1'b0}}};
    assign s1_sticky = (|s1_lo_shifted[ABITS-1:0]) | s1_trunc;

    // Subtracting one more spare ulp keeps sticky meaning "slightly above"
    assign s1_sum_raw = s1_add ? {1'b0, s1_hi_sig} + {1'b0, s1_lo_sig}
                               : {1'b0, s1_hi_sig} - {1'b0, s1_lo_sig}
                                 - (ABITS+1)'(s1_sticky);

    logic            s2_valid;
    logic            s2_sgn;
    logic [SW-1:0]   s2_scale;
    logic            s2_nar;
    logic            s2_both_zero;
    logic [ABITS:0]  s2_sum_raw;
    logic            s2_sticky;

    always_ff @(posedge clk)
    begin
        s2_sgn <= s1_hi.sgn;
        s2_scale <= s1_hi.scale;
        s2_nar <= s1_hi.nar | s1_lo.nar;
        s2_both_zero <= s1_hi.zero & s1_lo.zero;
        s2_sum_raw <= s1_sum_raw;
        s2_sticky <= s1_sticky;
    end

    // Stage 2 leading one search and normalization
    logic [LW-1:0]   s2_lead;
    logic [ABITS:0]  s2_norm;
    raw_sum_t        s2_sum;

    always_comb
    begin
        s2_lead = '0;
        for (int i = 0; i <= ABITS; i++)
        begin
            if (s2_sum_raw[i])
                s2_lead = LW'(i);
        end
    end

    assign s2_norm = s2_sum_raw << (LW'(ABITS) - s2_lead);
    assign s2_sum.sgn = s2_sgn;
    // Hidden bit sits at ABITS-1 before normalization
    assign s2_sum.scale = {s2_scale[SW-1], s2_scale} + DW'(s2_lead) - DW'(ABITS - 1);
    assign s2_sum.fraction = s2_norm[ABITS-1 -: FW+2];
    assign s2_sum.sticky = (|s2_norm[ABITS-FW-3:0]) | s2_sticky;
    assign s2_sum.nar = s2_nar;
    assign s2_sum.zero = s2_both_zero | (s2_sum_raw == '0);

    logic      s3_valid;
    raw_sum_t  s3_sum;
    raw_sum_t  s3_out;

    always_ff @(posedge clk)
    begin
        s3_sum <= s2_sum;
    end

    // Stage 3 output register, NaR wins over zero
    always_comb
    begin
        s3_out = s3_sum;
        s3_out.zero = s3_sum.zero & ~s3_sum.nar;
    end

    always_ff @(posedge clk)
    begin
        sum.s <= s3_out;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            sum.valid <= 1'b0;
        end
        else
        begin
            s1_valid <= src.valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            sum.valid <= s3_valid;
        end
    end

    // Operand fields unused on the sum link
    assign sum.a = '0;
    assign sum.b = '0;

endmodule

`default_nettype wire

// ==== rtl/posit_encode.sv ====
// Rounds and packs the raw sum into a posit and queues it for the consumer
// Results leave only against output credits, each pop returns an input credit
`timescale 1ns/1ps
`default_nettype none

`include "posit_config.svh"

module posit_encode (
    input  logic              clk,
    input  logic              reset,
    posit_raw_if.dst          sum,
    input  logic              out_credit,
    output logic              out_valid,
    output posit_pkg::posit_t out_result,
    output logic              in_credit
);
    import posit_pkg::*;

    localparam int N         = `POSIT_N;
    localparam int ES        = `POSIT_ES;
    localparam int DW        = `POSIT_SCALE_W + 1;
    localparam int TAIL_W    = ES + `POSIT_FRAC_W + 2;
    localparam int STR_W     = 2 * N;
    localparam int MAX_SCALE = (N - 2) << ES;
    localparam int DEPTH     = `POSIT_QUEUE_DEPTH;
    localparam int PTR_W     = $clog2(DEPTH);
    localparam int CNT_W     = $clog2(DEPTH + 1);

    function automatic posit_t encode_posit(input raw_sum_t v);
        logic signed [DW-1:0] k;
        logic [STR_W-1:0]     str;
        logic [N-2:0]         body;
        logic                 guard;
        logic                 sticky;
        posit_t               p;

        k = $signed(v.scale) >>> ES;
        // Regime, exponent, fraction laid out left aligned
        if (k >= 0)
            str = $signed({2'b10, v.scale[ES-1:0], v.fraction,
                           {(STR_W-2-TAIL_W){1'b0}}}) >>> k;
        else
            str = {2'b01, v.scale[ES-1:0], v.fraction, {(STR_W-2-TAIL_W){1'b0}}} >> (-k - 1);

        body = str[STR_W-1 -: N-1];
        guard = str[STR_W-N];
        sticky = (|str[STR_W-N-1:0]) | v.sticky;
        // Round to nearest, ties to even
        body = body + (N-1)'(guard & (body[0] | sticky));

        // Saturate, never round to zero or past maxpos
        if ($signed(v.scale) > MAX_SCALE)
            body = '1;
        else if ($signed(v.scale) < -MAX_SCALE)
            body = {{(N-2){1'b0}}, 1'b1};

        if (v.nar)
            p = {1'b1, {(N-1){1'b0}}};
        else if (v.zero)
            p = '0;
        else
            p = v.sgn ? -{1'b0, body} : {1'b0, body};
        return p;
    endfunction

    posit_t              enc_result;
    posit_t              queue_mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    q_count;
    logic [CNT_W-1:0]    credit_cnt;
    logic                pop;

    assign enc_result = encode_posit(sum.s);
    assign pop = (q_count != '0) && (credit_cnt != '0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_count <= '0;
            credit_cnt <= '0;
            out_valid <= 1'b0;
            in_credit <= 1'b0;
        end
        else
        begin
            if (sum.valid)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            q_count <= q_count + CNT_W'(sum.valid) - CNT_W'(pop);
            credit_cnt <= credit_cnt + CNT_W'(out_credit) - CNT_W'(pop);
            out_valid <= pop;
            in_credit <= pop;
        end
    end

    always_ff @(posedge clk)
    begin
        if (sum.valid)
            queue_mem[wr_ptr] <= enc_result;
        if (pop)
            out_result <= queue_mem[rd_ptr];
    end

    // Upstream credits must keep a full queue from taking another write
    assert property (@(posedge clk) disable iff (reset)
        sum.valid |-> (q_count < CNT_W'(DEPTH)) || pop);

    // Consumer never grants more than the queue depth
    assert property (@(posedge clk) disable iff (reset)
        (out_credit && !pop) |-> credit_cnt < CNT_W'(DEPTH));

endmodule

`default_nettype wire

// ==== rtl/posit_add_unit.sv ====
// Posit add/subtract unit with credit flow control on both sides
// Decode, four-stage raw adder, then rounding and the result queue
`timescale 1ns/1ps
`default_nettype none

module posit_add_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  posit_pkg::posit_op_e in_op,
    input  posit_pkg::posit_t    in_a,
    input  posit_pkg::posit_t    in_b,
    output logic                 in_credit,
    input  logic                 out_credit,
    output logic                 out_valid,
    output posit_pkg::posit_t    out_result
);

    posit_raw_if dec_if ();
    posit_raw_if sum_if ();

    posit_decode decode_i (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_a     (in_a),
        .in_b     (in_b),
        .raw      (dec_if.src)
    );

    posit_add_raw add_raw_i (
        .clk   (clk),
        .reset (reset),
        .src   (dec_if.dst),
        .sum   (sum_if.src)
    );

    posit_encode encode_i (
        .clk        (clk),
        .reset      (reset),
        .sum        (sum_if.dst),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_result (out_result),
        .in_credit  (in_credit)
    );

endmodule

`default_nettype wire

// ==== tests/tb_posit_add_unit.sv ====
// Testbench for the posit add unit that checks every result against an exact posit model
// Issues operands against input credits and grants output credits for pending results
`timescale 1ns/1ps
`default_nettype none

`include "posit_config.svh"

module tb_posit_add_unit;
    import posit_pkg::*;

    localparam int PN          = `POSIT_N;
    localparam int DEPTH       = `POSIT_QUEUE_DEPTH;
    // Fixed point LSB is minpos at 2^-28
    localparam int FIX_SHIFT   = 28;
    localparam int N_DIRECTED  = 25;
    localparam int N_SWEEP     = 40;
    localparam int N_RANDOM    = 500;
    localparam int NUM_OPS     = N_DIRECTED + N_SWEEP + N_RANDOM + DEPTH;
    localparam int CYCLE_LIMIT = NUM_OPS * 20 + 200;

    localparam int CONS_HOLD   = 0;
    localparam int CONS_ALWAYS = 1;
    localparam int CONS_RANDOM = 2;

    logic      clk;
    logic      reset;
    logic      in_valid;
    posit_op_e in_op;
    posit_t    in_a;
    posit_t    in_b;
    logic      in_credit;
    logic      out_credit;
    logic      out_valid;
    posit_t    out_result;

    integer    seed = 32'hc0bcb513;
    integer    credit_seed = 0;
    posit_t    exp_q[$];
    string     desc_q[$];
    int        issued_count = 0;
    int        result_count = 0;
    int        in_credit_count = 0;
    int        grants_count = 0;
    int        pending = 0;
    int        consumer_mode = CONS_HOLD;
    int        checks = 0;
    int        errors = 0;
    int        mark_checks = 0;
    int        mark_errors = 0;
    int        cycles = 0;

    posit_add_unit dut_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_a       (in_a),
        .in_b       (in_b),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Exact value of a posit times 2^28
    function automatic logic signed [63:0] decode_ref(input posit_t p);
        logic [PN-1:0]      m;
        logic               r;
        logic               done;
        logic [63:0]        sig;
        logic signed [63:0] val;
        int                 run;
        int                 i;
        int                 e;
        int                 fbits;
        int                 sc;

        if (p == '0)
            return 64'sd0;
        m = p[PN-1] ? -p : p;
        r = m[PN-2];
        run = 0;
        done = 1'b0;
        for (int j = PN - 2; j >= 0; j--)
        begin
            if (!done && m[j] == r)
                run++;
            else
                done = 1'b1;
        end
        // Skip regime and terminator
        i = PN - 3 - run;
        e = 0;
        if (i >= 0)
        begin
            e = m[i];
            i--;
        end
        sig = 64'd1;
        fbits = 0;
        while (i >= 0)
        begin
            sig = {sig[62:0], m[i]};
            fbits++;
            i--;
        end
        sc = 2 * (r ? run - 1 : -run) + e;
        val = sig << (sc + FIX_SHIFT - fbits);
        return p[PN-1] ? -val : val;
    endfunction

    // Nearest posit to an exact fixed point sum with ties to even on the bit string
    function automatic posit_t encode_ref(input logic signed [63:0] s);
        logic [63:0]   mag;
        logic [127:0]  str;
        logic [PN-2:0] body;
        logic          guard;
        logic          sticky;
        int            lead;
        int            sc;
        int            k;
        int            pos;

        if (s == 0)
            return '0;
        mag = (s < 0) ? -s : s;
        lead = 0;
        for (int j = 0; j < 64; j++)
        begin
            if (mag[j])
                lead = j;
        end
        sc = lead - FIX_SHIFT;
        if (sc >= FIX_SHIFT)
            body = '1;
        else
        begin
            k = sc >>> 1;
            str = '0;
            pos = 127;
            if (k >= 0)
            begin
                for (int j = 0; j <= k; j++)
                begin
                    str[pos] = 1'b1;
                    pos--;
                end
                pos--;
            end
            else
            begin
                pos = pos + k;
                str[pos] = 1'b1;
                pos--;
            end
            // Exponent bit is the low bit of the scale
            str[pos] = sc[0];
            pos--;
            for (int j = lead - 1; j >= 0; j--)
            begin
                str[pos] = mag[j];
                pos--;
            end
            body = str[127 -: PN-1];
            guard = str[128-PN];
            sticky = |str[127-PN:0];
            if (guard && (sticky || body[0]))
                body = body + 1'b1;
        end
        return (s < 0) ? -{1'b0, body} : {1'b0, body};
    endfunction

    function automatic posit_t ref_posit_add(input posit_op_e op, input posit_t a,
                                             input posit_t b);
        posit_t             nar;
        logic signed [63:0] va;
        logic signed [63:0] vb;

        nar = {1'b1, {(PN-1){1'b0}}};
        if (a == nar || b == nar)
            return nar;
        va = decode_ref(a);
        vb = decode_ref(b);
        if (op == OP_SUB)
            vb = -vb;
        return encode_ref(va + vb);
    endfunction

    task automatic check_posit(input posit_t got, input posit_t exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t: result of %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_credit(input int got, input int exp, input string what);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Waits for an input credit and presents one operation for a cycle
    task automatic issue(input posit_op_e op, input posit_t a, input posit_t b);
        while (DEPTH + in_credit_count - issued_count == 0)
            @(negedge clk);
        in_valid = 1'b1;
        in_op = op;
        in_a = a;
        in_b = b;
        exp_q.push_back(ref_posit_add(op, a, b));
        desc_q.push_back($sformatf("%h %s %h", a, (op == OP_SUB) ? "-" : "+", b));
        issued_count++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic issue_random();
        posit_op_e op;
        posit_t    a;
        posit_t    b;

        op = ($random(seed) & 1) ? OP_SUB : OP_ADD;
        a = posit_t'($random(seed));
        b = posit_t'($random(seed));
        issue(op, a, b);
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
            @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        drain();
        $display("%s: %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    // Results and returned input credits sampled before the edge updates them
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (out_valid === 1'b1)
            begin
                if (grants_count - result_count <= 0)
                begin
                    errors++;
                    $display("Result at %0t was presented without an output credit", $time);
                end
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("Result %h at %0t arrived with nothing issued", out_result, $time);
                end
                else
                    check_posit(out_result, exp_q.pop_front(), desc_q.pop_front());
                result_count++;
            end
            if (in_credit === 1'b1)
                in_credit_count++;
            if (DEPTH + in_credit_count - issued_count > DEPTH)
            begin
                errors++;
                $display("More input credits returned than items issued at %0t", $time);
            end
            pending = issued_count - result_count;
        end
    end

    // Consumer grants at most one credit per result still owed
    initial
    begin
        out_credit = 1'b0;
        forever
        begin
            @(negedge clk);
            out_credit = 1'b0;
            if (grants_count - result_count < pending && grants_count - result_count < DEPTH)
            begin
                if (consumer_mode == CONS_ALWAYS)
                    out_credit = 1'b1;
                else if (consumer_mode == CONS_RANDOM)
                    out_credit = ($random(credit_seed) & 1) != 0;
            end
            if (out_credit)
                grants_count++;
        end
    end

    initial
    begin
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d results still missing", cycles,
                 exp_q.size());
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        int ic_base;
        int rc_base;

        reset = 1'b1;
        in_valid = 1'b0;
        in_op = OP_ADD;
        in_a = '0;
        in_b = '0;
        credit_seed = seed + 1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        consumer_mode = CONS_RANDOM;
        issue(OP_ADD, 16'h4000, 16'h4000);
        issue(OP_SUB, 16'h4000, 16'h4000);
        issue(OP_ADD, 16'h5a3c, 16'h0000);
        issue(OP_ADD, 16'h0000, 16'h5a3c);
        issue(OP_SUB, 16'h0000, 16'h5a3c);
        issue(OP_ADD, 16'h5400, 16'hc000);
        issue(OP_SUB, 16'h4000, 16'hc000);
        issue(OP_ADD, 16'h3000, 16'hc000);
        finish_test("simple add and subtract");

        issue(OP_ADD, 16'h8000, 16'h4000);
        issue(OP_SUB, 16'h4000, 16'h8000);
        issue(OP_ADD, 16'h8000, 16'h8000);
        issue(OP_ADD, 16'h8000, 16'h0000);
        issue(OP_ADD, 16'h7fff, 16'h7fff);
        issue(OP_ADD, 16'h8001, 16'h8001);
        issue(OP_SUB, 16'h7fff, 16'h7fff);
        issue(OP_ADD, 16'h0001, 16'h0001);
        issue(OP_SUB, 16'h0001, 16'h0001);
        finish_test("special values");

        // 16'h00c0 is half an ulp of 1.0
        issue(OP_ADD, 16'h4000, 16'h0001);
        issue(OP_ADD, 16'h4000, 16'h00c0);
        issue(OP_ADD, 16'h4001, 16'h00c0);
        issue(OP_ADD, 16'h4000, 16'h00c1);
        issue(OP_SUB, 16'h4000, 16'h0001);
        issue(OP_SUB, 16'h4000, 16'h00c0);
        issue(OP_ADD, 16'h7ffe, 16'h4000);
        issue(OP_SUB, 16'h0002, 16'h4000);
        for (int n = 0; n < N_SWEEP; n++)
        begin
            posit_op_e op;
            posit_t    a;
            posit_t    b;

            op = ($random(seed) & 1) ? OP_SUB : OP_ADD;
            a = {2'b01, 14'($random(seed))};
            b = {5'b00000, 11'($random(seed))};
            issue(op, a, b);
        end
        finish_test("rounding with wide alignment");

        consumer_mode = CONS_ALWAYS;
        for (int n = 0; n < N_RANDOM; n++)
            issue_random();
        finish_test("random operands at full rate");

        consumer_mode = CONS_HOLD;
        ic_base = in_credit_count;
        rc_base = result_count;
        for (int n = 0; n < DEPTH; n++)
            issue_random();
        check_credit(DEPTH + in_credit_count - issued_count, 0, "input credits left");
        repeat (30) @(negedge clk);
        check_credit(in_credit_count - ic_base, 0, "input credits under back-pressure");
        check_credit(result_count - rc_base, 0, "results under back-pressure");
        consumer_mode = CONS_ALWAYS;
        drain();
        check_credit(in_credit_count - ic_base, DEPTH, "input credits after release");
        check_credit(result_count - rc_base, DEPTH, "results after release");
        check_credit(grants_count - result_count, 0, "unused output credits");
        finish_test("back-pressure");

        $display("Done: %0d checks, %0d errors, %0d results", checks, errors, result_count);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/posit_pkg.sv
rtl/posit_raw_if.sv
rtl/posit_decode.sv
rtl/posit_add_raw.sv
rtl/posit_encode.sv
rtl/posit_add_unit.sv
tests/tb_posit_add_unit.sv

// ==== Makefile ====
# Verilator build, run and lint for the posit add unit testbench
VERILATOR ?= verilator
TOP       ?= tb_posit_add_unit
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
